// ==== run_sim.sh ====
#!/bin/sh
# Build and run the hart debug unit testbench with Verilator.
# Exits 0 only when the log holds the pass line.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_hdu -Mdir obj_dir -f sim.f &&
./obj_dir/Vtb_hdu > sim.log 2>&1 ||
{ cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "^ALL CHECKS PASSED$" sim.log && exit 0 || exit 1

// ==== sim.f ====
+incdir+verilog
verilog/hdu_pkg.sv
verilog/hdu_debug_fsm.sv
verilog/hdu_halt_ctrl.sv
verilog/hdu_csr_regs.sv
verilog/hdu_top.sv
tests/hdu_asserts.sv
tests/tb_hdu.sv

// ==== tests/hdu_asserts.sv ====
/*
 * Handshake and CSR access assertions, bound into every hdu_top instance.
 * Checks are disabled while rst_n is low.
 */

`timescale 1ns/1ps

module hdu_asserts (
    input logic                clk,
    input logic                rst_n,
    input logic                dm_cmd_req,
    input logic                dm_cmd_resp,
    input logic                csr_ok,
    input hdu_pkg::dbg_state_e dbg_state,
    input hdu_pkg::hart_ctrl_t hart_ctrl
);
    import hdu_pkg::*;

    int unsigned fail_cnt = 0;    // Read by the testbench at the end

    // Response only while the debug module holds its request
    resp_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        dm_cmd_resp |-> dm_cmd_req)
        else begin
            $error("command response without a pending request");
            fail_cnt++;
        end

    // An accepted CSR access always falls inside a halt
    csr_ok_halted: assert property (@(posedge clk) disable iff (!rst_n)
        csr_ok |=> (dbg_state == DBG_HALTED))
        else begin
            $error("CSR access accepted while the hart runs");
            fail_cnt++;
        end

    ctrl_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(hart_ctrl))
        else begin
            $error("hart control outputs unknown");
            fail_cnt++;
        end

endmodule

bind hdu_top hdu_asserts i_hdu_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .dm_cmd_req  (dm_cmd_req),
    .dm_cmd_resp (dm_cmd_resp),
    .csr_ok      (csr_rsp.ok),
    .dbg_state   (dbg_state),
    .hart_ctrl   (hart_ctrl)
);

// ==== tests/tb_hdu.sv ====
/*
 * Random testbench of the hart debug unit, xorshift stimulus with seed 89.
 * Inputs change on the falling edge, outputs are sampled 2 ns later.
 */

`timescale 1ns/1ps

`include "hdu_defs.svh"

module tb_hdu;
    import hdu_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int N_ITER          = 16;
    localparam int WATCHDOG_CYCLES = (N_ITER + 4) * 200;  // Worst iteration stays under 200
    localparam int WAIT_LIMIT      = `HDU_TIMEOUT + 4;

    logic        clk = 1'b0;
    logic        rst_n;
    csr_req_t    csr;
    csr_rsp_t    csr_rsp;
    logic        dm_cmd_req;
    dbg_state_e  dm_cmd;
    logic        dm_cmd_resp;
    logic        dm_cmd_rcode;
    logic        dm_hart_event;
    dm_status_t  dm_status;
    hart_run_t   hart_run;
    xlen_t       hart_pc;
    hart_ctrl_t  hart_ctrl;
    logic        hart_dbg_halted;
    xlen_t       hart_new_pc;

    logic [31:0] rng_state;
    int          errors = 0;
    int          checks = 0;
    int          events_seen = 0;
    int          events_exp = 0;

    // Reference model
    dbg_state_e  m_state;
    logic        m_ebreakm;
    logic        m_stepie;
    logic        m_step;
    halt_cause_e m_cause;
    xlen_t       m_dpc;

    hdu_top i_hdu_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .csr             (csr),
        .csr_rsp         (csr_rsp),
        .dm_cmd_req      (dm_cmd_req),
        .dm_cmd          (dm_cmd),
        .dm_cmd_resp     (dm_cmd_resp),
        .dm_cmd_rcode    (dm_cmd_rcode),
        .dm_hart_event   (dm_hart_event),
        .dm_status       (dm_status),
        .hart_run        (hart_run),
        .hart_pc         (hart_pc),
        .hart_ctrl       (hart_ctrl),
        .hart_dbg_halted (hart_dbg_halted),
        .hart_new_pc     (hart_new_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (rst_n && dm_hart_event) begin
            events_seen++;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // DCSR as the debugger reads it
    function automatic xlen_t dcsr_value();
        return (xlen_t'(`HDU_DCSR_XDEBUGVER) << 28)
            | (xlen_t'(m_ebreakm) << `HDU_DCSR_EBREAKM_BIT)
            | (xlen_t'(m_stepie) << `HDU_DCSR_STEPIE_BIT)
            | (xlen_t'(m_cause) << `HDU_DCSR_CAUSE_LSB)
            | (xlen_t'(m_step) << `HDU_DCSR_STEP_BIT)
            | xlen_t'(`HDU_DCSR_PRV);
    endfunction

    function automatic xlen_t apply_csr_cmd(input csr_cmd_e cmd, input xlen_t old_val,
                                            input xlen_t wdata);
        case (cmd)
            CSR_WRITE: return wdata;
            CSR_SET:   return old_val | wdata;
            CSR_CLEAR: return old_val & ~wdata;
            default:   return old_val;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic csr_access(input csr_cmd_e cmd, input csr_addr_t addr, input xlen_t wdata);
        logic  is_dcsr;
        logic  exp_ok;
        xlen_t old_val;
        xlen_t new_val;
        is_dcsr = (addr == `HDU_CSR_DCSR);
        exp_ok  = (m_state == DBG_HALTED) & (is_dcsr | (addr == `HDU_CSR_DPC));
        old_val = is_dcsr ? dcsr_value() : m_dpc;
        @(negedge clk);
        csr.req   = 1'b1;
        csr.cmd   = cmd;
        csr.addr  = addr;
        csr.wdata = wdata;
        #2;
        check("csr_ok", 32'(exp_ok), 32'(csr_rsp.ok));
        if (exp_ok) begin
            check("csr_rdata", old_val, csr_rsp.rdata);
            new_val = apply_csr_cmd(cmd, old_val, wdata);
            if (is_dcsr) begin
                m_ebreakm = new_val[`HDU_DCSR_EBREAKM_BIT];
                m_stepie  = new_val[`HDU_DCSR_STEPIE_BIT];
                m_step    = new_val[`HDU_DCSR_STEP_BIT];
            end else begin
                m_dpc = new_val;
            end
        end
        @(negedge clk);
        csr.req = 1'b0;
    endtask

    task automatic random_csr_ops(input int count);
        logic [31:0] r;
        csr_addr_t   addr;
        repeat (count) begin
            r = next_rand();
            case (r[1:0])
                2'd0, 2'd2: addr = `HDU_CSR_DCSR;
                2'd1:       addr = `HDU_CSR_DPC;
                default:    addr = 12'h7C0 + csr_addr_t'(r[7:4]);  // Never decoded
            endcase
            csr_access(csr_cmd_e'(r[9:8]), addr, next_rand());
        end
    endtask

    task automatic drive_hart_random(input logic hold_busy);
        logic [31:0] r;
        r = next_rand();
        hart_run.exu_busy = hold_busy | (r[1:0] != 2'b00);
        hart_pc = next_rand();
    endtask

    // ------------------------------
    // Halt and resume sequences
    // ------------------------------
    task automatic debugger_halt(input logic hold_busy);
        int    cyc;
        xlen_t pc_at_resp;
        cyc = 0;
        @(negedge clk);
        dm_cmd_req = 1'b1;
        dm_cmd     = DBG_HALTED;
        drive_hart_random(hold_busy);
        #2;
        while (!dm_cmd_resp && cyc < WAIT_LIMIT) begin
            @(negedge clk);
            drive_hart_random(hold_busy);
            #2;
            cyc++;
        end
        pc_at_resp = hart_pc;
        if (!dm_cmd_resp) begin
            errors++;
            $display("Halt command got no response within %0d cycles", WAIT_LIMIT);
        end
        check("halt_rcode", 32'd0, 32'(dm_cmd_rcode));
        @(negedge clk);
        dm_cmd_req        = 1'b0;
        hart_run.exu_busy = 1'b0;
        #2;
        m_state = DBG_HALTED;
        m_cause = CAUSE_DMREQ;
        m_dpc   = pc_at_resp;
        events_exp++;
        check("halt_state", 32'(DBG_HALTED), 32'(dm_status.dbg_state));
        check("halt_ebreak_status", 32'd0, 32'(dm_status.ebreak));
        check("halt_new_pc", m_dpc, hart_new_pc);
        check("halt_flag", 32'd1, 32'(hart_dbg_halted));
    endtask

    task automatic resume();
        int cyc;
        cyc = 0;
        @(negedge clk);
        dm_cmd_req = 1'b1;
        dm_cmd     = DBG_RUN;
        #2;
        while (!dm_cmd_resp && cyc < WAIT_LIMIT) begin
            @(negedge clk);
            #2;
            cyc++;
        end
        if (!dm_cmd_resp) begin
            errors++;
            $display("Resume command got no response within %0d cycles", WAIT_LIMIT);
        end
        check("resume_latency", 32'd2, 32'(cyc));
        check("resume_halted_drop", 32'd0, 32'(hart_dbg_halted));
        @(negedge clk);
        dm_cmd_req = 1'b0;
        #2;
        m_state = DBG_RUN;
        events_exp++;
        check("resume_state", 32'(DBG_RUN), 32'(dm_status.dbg_state));
        check("resume_irq_dsbl", 32'(m_step & ~m_stepie), 32'(hart_ctrl.irq_dsbl));
        check("resume_sstep_en", 32'(m_step), 32'(hart_ctrl.sstep_en));
        check("resume_new_pc", m_dpc, hart_new_pc);
    endtask

    // Halts without a command, no response allowed
    task automatic wait_for_halt(input string name);
        int cyc;
        cyc = 0;
        while (dm_status.dbg_state != DBG_HALTED && cyc < WAIT_LIMIT) begin
            if (dm_cmd_resp) begin
                errors++;
                $display("%s halt answered although no command was pending", name);
            end
            @(negedge clk);
            #2;
            cyc++;
        end
        if (dm_status.dbg_state != DBG_HALTED) begin
            errors++;
            $display("%s halt did not happen within %0d cycles", name, WAIT_LIMIT);
        end
        events_exp++;
        m_state = DBG_HALTED;
        check("halt_ctrl_cleared", 32'd0,
              32'({hart_ctrl.irq_dsbl, hart_ctrl.sstep_en, hart_ctrl.no_commit}));
    endtask

    task automatic step_halt();
        xlen_t pc;
        pc = next_rand();
        @(negedge clk);
        hart_run.exu_busy = 1'b0;
        hart_run.instret  = 1'b1;
        hart_pc           = pc;
        @(negedge clk);
        hart_run.instret = 1'b0;
        #2;
        wait_for_halt("Single step");
        m_cause = CAUSE_SSTEP;
        m_dpc   = pc;
        check("step_new_pc", m_dpc, hart_new_pc);
    endtask

    task automatic ebreak_halt();
        xlen_t pc;
        pc = next_rand();
        @(negedge clk);
        hart_run.exu_busy = 1'b0;
        hart_run.brkpt    = 1'b1;
        hart_pc           = pc;
        #2;
        check("ebreak_no_commit", 32'd1, 32'(hart_ctrl.no_commit));
        @(negedge clk);
        hart_run.brkpt = 1'b0;
        #2;
        wait_for_halt("EBREAK");
        m_cause = CAUSE_EBREAK;
        m_dpc   = pc;
        check("ebreak_status", 32'd1, 32'(dm_status.ebreak));
        check("ebreak_new_pc", m_dpc, hart_new_pc);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int iter;
        rst_n      = 1'b0;
        csr        = '0;
        dm_cmd_req = 1'b0;
        dm_cmd     = DBG_RESET;
        hart_run   = '0;
        hart_pc    = '0;
        rng_state  = 32'd89;
        m_state    = DBG_RESET;
        m_ebreakm  = 1'b0;
        m_stepie   = 1'b0;
        m_step     = 1'b0;
        m_cause    = CAUSE_NONE;
        m_dpc      = '0;

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        #2;
        check("reset_ctrl", 32'd0,
              32'({hart_ctrl.irq_dsbl, hart_ctrl.sstep_en, hart_ctrl.no_commit}));
        check("reset_outputs", 32'd0, 32'({dm_cmd_resp, dm_hart_event, hart_dbg_halted}));
        check("reset_new_pc", 32'd0, hart_new_pc);

        // Reset exit with no command pending
        @(negedge clk);
        hart_run.init_pc = 1'b1;
        hart_pc          = next_rand();
        @(negedge clk);
        hart_run.init_pc = 1'b0;
        #2;
        m_state    = DBG_RUN;
        events_exp = 1;
        check("reset_exit_state", 32'(DBG_RUN), 32'(dm_status.dbg_state));
        check("reset_exit_event", 32'd1, 32'(dm_hart_event));
        repeat (2) @(negedge clk);
        check("reset_exit_event_count", 32'd1, 32'(events_seen));

        random_csr_ops(4);                     // Refused while running
        debugger_halt(1'b0);

        for (iter = 0; iter < N_ITER; iter++) begin
            random_csr_ops(4);
            csr_access(CSR_WRITE, `HDU_CSR_DCSR, next_rand());
            resume();
            random_csr_ops(2);
            if (m_step) begin
                step_halt();
            end else if (m_ebreakm) begin
                ebreak_halt();
            end else begin
                debugger_halt(1'b0);
            end
            csr_access(CSR_NONE, `HDU_CSR_DCSR, '0);
            csr_access(CSR_NONE, `HDU_CSR_DPC, '0);
        end

        // Busy hart, only the timeout ends the halt request
        csr_access(CSR_WRITE, `HDU_CSR_DCSR, '0);
        resume();
        debugger_halt(1'b1);
        csr_access(CSR_NONE, `HDU_CSR_DCSR, '0);

        repeat (2) @(negedge clk);
        check("event_count", 32'(events_exp), 32'(events_seen));
        check("assertion_failures", 32'd0, 32'(i_hdu_top.i_hdu_asserts.fail_cnt));

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/hdu_csr_regs.sv ====
/*
 * Debug CSRs DCSR and DPC, accessible only while the hart is halted.
 * A halt capture of DPC wins over a CSR write in the same cycle.
 */

`timescale 1ns/1ps

`include "hdu_defs.svh"

module hdu_csr_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  hdu_pkg::csr_req_t    csr,
    output hdu_pkg::csr_rsp_t    csr_rsp,
    input  logic                 halted,
    input  logic                 csr_update,
    input  hdu_pkg::halt_cause_e halt_cause,
    input  hdu_pkg::xlen_t       hart_pc,
    output hdu_pkg::dcsr_ctrl_t  dcsr,
    output hdu_pkg::xlen_t       new_pc
);
    import hdu_pkg::*;

    logic        dcsr_sel;
    logic        dpc_sel;
    logic        hit;
    logic        csr_wr;
    xlen_t       dcsr_rd;
    xlen_t       rd_data;
    xlen_t       wr_data;
    xlen_t       dpc_q;
    dcsr_ctrl_t  dcsr_q;
    halt_cause_e dcsr_cause;

    // ------------------------------
    // Decode and read-modify-write
    // ------------------------------
    assign dcsr_sel = (csr.addr == `HDU_CSR_DCSR);
    assign dpc_sel  = (csr.addr == `HDU_CSR_DPC);
    assign hit      = csr.req & halted & (dcsr_sel | dpc_sel);
    assign csr_wr   = hit & (csr.cmd != CSR_NONE);

    always_comb begin
        dcsr_rd                                 = '0;  // Unlisted bits read zero
        dcsr_rd[`HDU_XLEN-1 -: 4]               = `HDU_DCSR_XDEBUGVER;
        dcsr_rd[`HDU_DCSR_EBREAKM_BIT]          = dcsr_q.ebreakm;
        dcsr_rd[`HDU_DCSR_STEPIE_BIT]           = dcsr_q.stepie;
        dcsr_rd[`HDU_DCSR_CAUSE_LSB +: 3]       = dcsr_cause;
        dcsr_rd[`HDU_DCSR_STEP_BIT]             = dcsr_q.step;
        dcsr_rd[1:0]                            = `HDU_DCSR_PRV;
    end

    assign rd_data = dcsr_sel ? dcsr_rd : (dpc_sel ? dpc_q : '0);

    always_comb begin
        case (csr.cmd)
            CSR_WRITE: wr_data = csr.wdata;
            CSR_SET:   wr_data = rd_data | csr.wdata;
            CSR_CLEAR: wr_data = rd_data & ~csr.wdata;
            default:   wr_data = rd_data;
        endcase
    end

    assign csr_rsp.ok    = hit;
    assign csr_rsp.rdata = rd_data;

    // ------------------------------
    // DCSR
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dcsr_q <= '0;
        end else if (csr_wr & dcsr_sel) begin
            dcsr_q.ebreakm <= wr_data[`HDU_DCSR_EBREAKM_BIT];
            dcsr_q.stepie  <= wr_data[`HDU_DCSR_STEPIE_BIT];
            dcsr_q.step    <= wr_data[`HDU_DCSR_STEP_BIT];
        end
    end

    // Cause is read only, set on halt entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dcsr_cause <= CAUSE_NONE;
        end else if (csr_update) begin
            dcsr_cause <= halt_cause;
        end
    end

    // ------------------------------
    // DPC
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dpc_q <= '0;
        end else if (csr_update) begin
            dpc_q <= hart_pc;            // PC of the halted instruction
        end else if (csr_wr & dpc_sel) begin
            dpc_q <= wr_data;
        end
    end

    assign dcsr   = dcsr_q;
    assign new_pc = dpc_q;               // Resume address

endmodule

// ==== verilog/hdu_debug_fsm.sv ====
/*
 * Debug state machine RESET, RUN, HALTED with the debug-module handshake.
 * Halt latency depends on the hart, resume answers 2 cycles after the request.
 * Commands that do not match the current state are ignored, never answered.
 */

`timescale 1ns/1ps

module hdu_debug_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 dm_cmd_req,
    input  hdu_pkg::dbg_state_e  dm_cmd,
    input  logic                 init_pc,
    input  logic                 halt_ack,
    input  hdu_pkg::halt_cause_e halt_cause,
    output logic                 dm_cmd_resp,
    output logic                 dm_cmd_rcode,
    output logic                 dm_hart_event,
    output hdu_pkg::dm_status_t  dm_status,
    output hdu_pkg::dbg_state_e  dbg_state,
    output logic                 halted,
    output logic                 halt_req,
    output logic                 rctl_wr,
    output logic                 rctl_clr,
    output logic                 csr_update
);
    import hdu_pkg::*;

    dbg_state_e state;
    dbg_state_e state_nxt;
    logic       trans;         // Command accepted, waiting on the hart
    logic       trans_nxt;
    logic       update;        // State change happens this cycle
    logic       update_nxt;
    logic       event_q;
    logic       event_nxt;
    logic       halt_cmd;
    logic       resume_cmd;

    assign halt_cmd   = dm_cmd_req & (dm_cmd == DBG_HALTED);
    assign resume_cmd = dm_cmd_req & (dm_cmd == DBG_RUN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= DBG_RESET;
            trans   <= 1'b0;
            update  <= 1'b0;
            event_q <= 1'b0;
        end else begin
            state   <= state_nxt;
            trans   <= trans_nxt;
            update  <= update_nxt;
            event_q <= event_nxt;
        end
    end

    // ------------------------------
    // Next state and handshake
    // ------------------------------
    always_comb begin
        state_nxt    = state;
        trans_nxt    = trans;
        update_nxt   = update;
        event_nxt    = 1'b0;
        dm_cmd_resp  = 1'b0;
        dm_cmd_rcode = 1'b1;
        halted       = 1'b0;
        halt_req     = 1'b0;
        rctl_wr      = 1'b0;
        rctl_clr     = 1'b0;
        csr_update   = 1'b0;

        case (state)
            DBG_RESET: begin
                trans_nxt  = 1'b0;
                update_nxt = 1'b0;
                if (init_pc) begin
                    event_nxt = 1'b1;
                    if (halt_cmd) begin          // Halt straight out of reset
                        dm_cmd_resp  = 1'b1;
                        dm_cmd_rcode = 1'b0;
                        csr_update   = 1'b1;
                        state_nxt    = DBG_HALTED;
                    end else begin
                        state_nxt = DBG_RUN;
                    end
                end
            end

            DBG_RUN: begin
                if (update) begin
                    halted       = 1'b1;
                    dm_cmd_resp  = dm_cmd_req;  // Silent for EBREAK and step halts
                    dm_cmd_rcode = 1'b0;
                    csr_update   = 1'b1;
                    rctl_clr     = 1'b1;
                    update_nxt   = 1'b0;
                    event_nxt    = 1'b1;
                    state_nxt    = DBG_HALTED;
                end else if (trans) begin
                    halt_req = 1'b1;
                    if (halt_ack) begin
                        trans_nxt  = 1'b0;
                        update_nxt = 1'b1;
                    end
                end else if (halt_ack) begin
                    update_nxt = 1'b1;           // Spontaneous halt
                end else if (halt_cmd) begin
                    trans_nxt = 1'b1;
                end
            end

            DBG_HALTED: begin
                if (update) begin
                    dm_cmd_resp  = 1'b1;
                    dm_cmd_rcode = 1'b0;
                    update_nxt   = 1'b0;
                    event_nxt    = 1'b1;
                    state_nxt    = DBG_RUN;
                end else begin
                    halted = 1'b1;
                    if (trans) begin
                        trans_nxt  = 1'b0;
                        update_nxt = 1'b1;
                    end else if (resume_cmd) begin
                        trans_nxt = 1'b1;
                        rctl_wr   = 1'b1;        // Run control from DCSR
                    end
                end
            end

            default: begin
                trans_nxt  = 1'b0;
                update_nxt = 1'b0;
                state_nxt  = DBG_RESET;
            end
        endcase
    end

    assign dm_hart_event       = event_q;
    assign dbg_state           = state;
    assign dm_status.dbg_state = state;
    assign dm_status.ebreak    = (state == DBG_HALTED) & (halt_cause == CAUSE_EBREAK);

endmodule

// ==== verilog/hdu_defs.svh ====
/*
 * Widths, debug CSR addresses and DCSR field positions of the hart debug unit.
 * HDU_TIMEOUT must stay a power of two, the timeout counter wraps on it.
 */

`ifndef HDU_DEFS_SVH
`define HDU_DEFS_SVH

// ------------------------------
// Widths
// ------------------------------
`define HDU_XLEN              32
`define HDU_CSR_ADDR_W        12

// Debug CSR addresses
`define HDU_CSR_DCSR          12'h7B0
`define HDU_CSR_DPC           12'h7B1

// ------------------------------
// DCSR layout
// ------------------------------
`define HDU_DCSR_EBREAKM_BIT  15
`define HDU_DCSR_STEPIE_BIT   11
`define HDU_DCSR_STEP_BIT     2
`define HDU_DCSR_CAUSE_LSB    6       // 3-bit cause field
`define HDU_DCSR_XDEBUGVER    4'd4    // Bits 31..28
`define HDU_DCSR_PRV          2'd3    // Bits 1..0, machine mode only

// Cycles a halt request may wait on a busy hart
`define HDU_TIMEOUT           64

`endif

// ==== verilog/hdu_halt_ctrl.sv ====
/*
 * Halt cause detection, halt cause latch, halt timeout and run control.
 * Cause priority is EBREAK, then debugger request, then single step.
 */

`timescale 1ns/1ps

`include "hdu_defs.svh"

module hdu_halt_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  hdu_pkg::hart_run_t   hart_run,
    input  logic                 halted,
    input  logic                 halt_req,
    input  logic                 rctl_wr,
    input  logic                 rctl_clr,
    input  hdu_pkg::dcsr_ctrl_t  dcsr,
    output logic                 halt_ack,
    output hdu_pkg::halt_cause_e halt_cause,
    output hdu_pkg::hart_ctrl_t  hart_ctrl
);
    import hdu_pkg::*;

    localparam int unsigned TMO_W = $clog2(`HDU_TIMEOUT);

    logic             rctl_irq_dsbl;
    logic             rctl_sstep;
    logic             rctl_ebreakm;
    logic             cause_sstep;
    logic             cause_ebreak;
    logic [TMO_W-1:0] tmo_cnt;
    logic             tmo_flag;
    halt_cause_e      cause_nxt;
    halt_cause_e      cause_q;

    // ------------------------------
    // Run control register
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rctl_irq_dsbl <= 1'b0;
            rctl_sstep    <= 1'b0;
            rctl_ebreakm  <= 1'b0;
        end else if (rctl_clr) begin
            rctl_irq_dsbl <= 1'b0;
            rctl_sstep    <= 1'b0;
            rctl_ebreakm  <= 1'b0;
        end else if (rctl_wr) begin
            rctl_irq_dsbl <= dcsr.step & ~dcsr.stepie;  // No interrupts while stepping
            rctl_sstep    <= dcsr.step;
            rctl_ebreakm  <= dcsr.ebreakm;
        end
    end

    assign cause_sstep  = rctl_sstep & hart_run.instret;
    assign cause_ebreak = rctl_ebreakm & hart_run.brkpt;

    // Busy hart only holds off the halt until the timeout
    assign halt_ack = ~halted &
        (tmo_flag | (~hart_run.exu_busy & (cause_ebreak | halt_req | cause_sstep)));

    always_comb begin
        if (cause_ebreak) begin
            cause_nxt = CAUSE_EBREAK;
        end else if (halt_req) begin
            cause_nxt = CAUSE_DMREQ;
        end else if (cause_sstep) begin
            cause_nxt = CAUSE_SSTEP;
        end else begin
            cause_nxt = CAUSE_NONE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cause_q <= CAUSE_NONE;
        end else if (halt_ack) begin
            cause_q <= cause_nxt;
        end
    end

    // ------------------------------
    // Halt request timeout
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tmo_cnt <= '1;
        end else if (rctl_wr) begin
            tmo_cnt <= '1;                 // Fresh budget on every resume
        end else if (halt_req & ~halt_ack) begin
            tmo_cnt <= tmo_cnt - TMO_W'(1);
        end
    end

    assign tmo_flag = (tmo_cnt == '0);

    assign halt_cause          = cause_q;
    assign hart_ctrl.irq_dsbl  = rctl_irq_dsbl;
    assign hart_ctrl.sstep_en  = rctl_sstep;
    assign hart_ctrl.no_commit = cause_ebreak;  // Breakpoint instruction must not retire

endmodule

// ==== verilog/hdu_pkg.sv ====
/*
 * Shared types of the hart debug unit.
 * The debug-module command reuses the state enum: RUN resumes, HALTED halts.
 */

`include "hdu_defs.svh"

package hdu_pkg;

    typedef logic [`HDU_XLEN-1:0]       xlen_t;
    typedef logic [`HDU_CSR_ADDR_W-1:0] csr_addr_t;

    typedef enum logic [1:0] {
        DBG_RESET  = 2'd0,
        DBG_RUN    = 2'd1,
        DBG_HALTED = 2'd2
    } dbg_state_e;

    // Codes as in the dcsr cause field
    typedef enum logic [2:0] {
        CAUSE_NONE   = 3'd0,
        CAUSE_EBREAK = 3'd1,
        CAUSE_DMREQ  = 3'd3,
        CAUSE_SSTEP  = 3'd4
    } halt_cause_e;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_cmd_e;

    // ------------------------------
    // Grouped ports
    // ------------------------------
    typedef struct packed {
        logic      req;
        csr_cmd_e  cmd;
        csr_addr_t addr;
        xlen_t     wdata;
    } csr_req_t;

    typedef struct packed {
        logic  ok;       // Hit on a debug CSR while halted
        xlen_t rdata;
    } csr_rsp_t;

    typedef struct packed {
        logic exu_busy;
        logic instret;
        logic init_pc;   // Reset exit
        logic brkpt;     // EBREAK in execution
    } hart_run_t;

    typedef struct packed {
        logic irq_dsbl;
        logic sstep_en;
        logic no_commit;
    } hart_ctrl_t;

    typedef struct packed {
        logic ebreakm;
        logic stepie;
        logic step;
    } dcsr_ctrl_t;

    typedef struct packed {
        dbg_state_e dbg_state;
        logic       ebreak;
    } dm_status_t;

endpackage

// ==== verilog/hdu_top.sv ====
/*
 * Hart debug unit top. CSR response is combinational in the request cycle.
 * The debug module must not issue a command that does not match the state.
 */

`timescale 1ns/1ps

module hdu_top (
    input  logic               clk,
    input  logic               rst_n,
    // CSR master
    input  hdu_pkg::csr_req_t   csr,
    output hdu_pkg::csr_rsp_t   csr_rsp,
    // Debug module
    input  logic               dm_cmd_req,
    input  hdu_pkg::dbg_state_e dm_cmd,
    output logic               dm_cmd_resp,
    output logic               dm_cmd_rcode,
    output logic               dm_hart_event,
    output hdu_pkg::dm_status_t dm_status,
    // Hart
    input  hdu_pkg::hart_run_t  hart_run,
    input  hdu_pkg::xlen_t      hart_pc,
    output hdu_pkg::hart_ctrl_t hart_ctrl,
    output logic               hart_dbg_halted,
    output hdu_pkg::xlen_t      hart_new_pc
);
    import hdu_pkg::*;

    dbg_state_e  dbg_state;    // Observed by the bound checkers
    halt_cause_e halt_cause;
    dcsr_ctrl_t  dcsr;
    logic        halt_req;
    logic        halt_ack;
    logic        rctl_wr;
    logic        rctl_clr;
    logic        csr_update;

    hdu_debug_fsm i_debug_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .dm_cmd_req    (dm_cmd_req),
        .dm_cmd        (dm_cmd),
        .init_pc       (hart_run.init_pc),
        .halt_ack      (halt_ack),
        .halt_cause    (halt_cause),
        .dm_cmd_resp   (dm_cmd_resp),
        .dm_cmd_rcode  (dm_cmd_rcode),
        .dm_hart_event (dm_hart_event),
        .dm_status     (dm_status),
        .dbg_state     (dbg_state),
        .halted        (hart_dbg_halted),
        .halt_req      (halt_req),
        .rctl_wr       (rctl_wr),
        .rctl_clr      (rctl_clr),
        .csr_update    (csr_update)
    );

    hdu_halt_ctrl i_halt_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .hart_run   (hart_run),
        .halted     (hart_dbg_halted),
        .halt_req   (halt_req),
        .rctl_wr    (rctl_wr),
        .rctl_clr   (rctl_clr),
        .dcsr       (dcsr),
        .halt_ack   (halt_ack),
        .halt_cause (halt_cause),
        .hart_ctrl  (hart_ctrl)
    );

    hdu_csr_regs i_csr_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr        (csr),
        .csr_rsp    (csr_rsp),
        .halted     (hart_dbg_halted),
        .csr_update (csr_update),
        .halt_cause (halt_cause),
        .hart_pc    (hart_pc),
        .dcsr       (dcsr),
        .new_pc     (hart_new_pc)
    );

endmodule
